/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// **************************************************
// data path
// **************************************************

// data word and address width
`define CORE_XLEN 32

// **************************************************
// data memory model
// **************************************************

// number of 32-bit words
`define MEM_WORDS 256
// cycles from read accept to the valid pulse, 1 or more
`define MEM_READ_LATENCY 3
// cycles with ready low after a write is accepted
`define MEM_WRITE_BUSY 2

`endif

/* core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    // **************************************************
    // memory operation codes
    // **************************************************

    // no memory access
    localparam logic [3:0] MEN_X              = 4'd0;

    // stores
    localparam logic [3:0] MEN_SB             = 4'd1;
    localparam logic [3:0] MEN_SH             = 4'd2;
    localparam logic [3:0] MEN_SW             = 4'd3;

    // loads, signed and unsigned
    localparam logic [3:0] MEN_LB             = 4'd4;
    localparam logic [3:0] MEN_LBU            = 4'd5;
    localparam logic [3:0] MEN_LH             = 4'd6;
    localparam logic [3:0] MEN_LHU            = 4'd7;
    localparam logic [3:0] MEN_LW             = 4'd8;

    // atomic swap, run as a word load then a word store
    localparam logic [3:0] MEN_AMOSWAP_W_AQRL = 4'd9;

    // **************************************************
    // data word views
    // **************************************************

    // one memory word seen as bytes or as halves
    // byte 0 and half 0 are the low bits
    typedef union packed {
        logic [`CORE_XLEN-1:0]              word;
        logic [`CORE_XLEN/8-1:0][7:0]       bytes;
        logic [`CORE_XLEN/16-1:0][15:0]     halves;
    } mem_word_u;

endpackage

/* memory_stage.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,

    // from the execute stage
    input  logic                    mem_valid,
    input  logic [31:0]             mem_reg_pc,
    input  logic [31:0]             mem_inst,
    input  logic [63:0]             mem_inst_id,
    input  logic [3:0]              mem_op,
    input  logic [`CORE_XLEN-1:0]   mem_alu_out,
    input  logic [`CORE_XLEN-1:0]   mem_rs2_data,

    // to write back
    output logic                    mem_wb_valid,
    output logic [31:0]             mem_wb_reg_pc,
    output logic [31:0]             mem_wb_inst,
    output logic [63:0]             mem_wb_inst_id,
    output logic [3:0]              mem_wb_op,
    output logic [`CORE_XLEN-1:0]   mem_wb_alu_out,
    output logic [`CORE_XLEN-1:0]   mem_wb_mem_data,

    input  logic                    pipeline_flush,
    output logic                    memory_unit_stall,

    // data memory command and response
    output logic                    memu_cmd_start,
    output logic                    memu_cmd_write,
    input  logic                    memu_cmd_ready,
    input  logic                    memu_valid,
    output logic [`CORE_XLEN-1:0]   memu_addr,
    output logic [`CORE_XLEN-1:0]   memu_wdata,
    output logic [`CORE_XLEN-1:0]   memu_wmask,
    input  logic [`CORE_XLEN-1:0]   memu_rdata
);

    import core_pkg::*;

    localparam logic [1:0] ST_WAIT            = 2'd0;
    localparam logic [1:0] ST_WAIT_READY      = 2'd1;
    localparam logic [1:0] ST_WAIT_READ_VALID = 2'd2;

    logic [1:0]     state;
    // operation being run, becomes a word store in the second half of a swap
    logic [3:0]     cur_op;
    logic           done_valid;
    logic [63:0]    done_id;
    mem_word_u      saved_rdata;

    logic           may_start;
    logic           start_new;
    logic           cur_is_store;
    logic           cmd_accept;

    // **************************************************
    // instruction tracking
    // **************************************************

    // a held instruction with the id of the last completed one is not rerun
    assign may_start    = !done_valid || (done_id != mem_inst_id);
    assign start_new    = mem_valid && may_start && (mem_op != MEN_X);

    assign cur_is_store = (cur_op == MEN_SB) || (cur_op == MEN_SH) || (cur_op == MEN_SW);
    assign cmd_accept   = memu_cmd_start && memu_cmd_ready;

    assign memory_unit_stall = mem_valid && ((state != ST_WAIT) || start_new);

    // **************************************************
    // memory command
    // **************************************************

    function automatic logic [`CORE_XLEN-1:0] gen_mask(input logic [3:0] op);
        case (op)
            MEN_SB:  return `CORE_XLEN'('hff);
            MEN_SH:  return `CORE_XLEN'('hffff);
            default: return '1;
        endcase
    endfunction

    // held high until the memory takes it, dropped on a flush
    assign memu_cmd_start = (state == ST_WAIT_READY) && mem_valid && !pipeline_flush;
    assign memu_cmd_write = cur_is_store;
    assign memu_addr      = mem_alu_out;
    assign memu_wdata     = mem_rs2_data;
    assign memu_wmask     = gen_mask(cur_op);

    // **************************************************
    // state machine
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_WAIT;
            cur_op     <= MEN_X;
            done_valid <= 1'b0;
            done_id    <= '0;
        end else if (pipeline_flush) begin
            state      <= ST_WAIT;
            cur_op     <= MEN_X;
            done_valid <= 1'b0;
        end else if (!mem_valid) begin
            state      <= ST_WAIT;
            cur_op     <= MEN_X;
        end else begin
            case (state)
                ST_WAIT: begin
                    // latch the operation, command goes out next cycle
                    if (start_new) begin
                        cur_op <= mem_op;
                        state  <= ST_WAIT_READY;
                    end
                end
                ST_WAIT_READY: begin
                    if (cmd_accept) begin
                        if (cur_is_store) begin
                            state      <= ST_WAIT;
                            cur_op     <= MEN_X;
                            done_valid <= 1'b1;
                            done_id    <= mem_inst_id;
                        end else begin
                            state <= ST_WAIT_READ_VALID;
                        end
                    end
                end
                ST_WAIT_READ_VALID: begin
                    if (memu_valid) begin
                        if (cur_op == MEN_AMOSWAP_W_AQRL) begin
                            // second half of the swap
                            cur_op <= MEN_SW;
                            state  <= ST_WAIT_READY;
                        end else begin
                            state      <= ST_WAIT;
                            cur_op     <= MEN_X;
                            done_valid <= 1'b1;
                            done_id    <= mem_inst_id;
                        end
                    end
                end
                default: begin
                    state  <= ST_WAIT;
                    cur_op <= MEN_X;
                end
            endcase
        end
    end

    // read data, kept through the store of a swap
    always_ff @(posedge clk) begin
        if ((state == ST_WAIT_READ_VALID) && memu_valid) begin
            saved_rdata.word <= memu_rdata;
        end
    end

    // **************************************************
    // load extension and write back
    // **************************************************

    function automatic logic [`CORE_XLEN-1:0] extend_load(input logic [3:0] op,
                                                           input mem_word_u rd);
        case (op)
            MEN_LB:  return {{(`CORE_XLEN-8){rd.bytes[0][7]}}, rd.bytes[0]};
            MEN_LBU: return {{(`CORE_XLEN-8){1'b0}}, rd.bytes[0]};
            MEN_LH:  return {{(`CORE_XLEN-16){rd.halves[0][15]}}, rd.halves[0]};
            MEN_LHU: return {{(`CORE_XLEN-16){1'b0}}, rd.halves[0]};
            // word load, and the old word of a swap
            default: return rd.word;
        endcase
    endfunction

    assign mem_wb_valid    = mem_valid && !pipeline_flush;
    assign mem_wb_reg_pc   = mem_reg_pc;
    assign mem_wb_inst     = mem_inst;
    assign mem_wb_inst_id  = mem_inst_id;
    assign mem_wb_op       = mem_op;
    assign mem_wb_alu_out  = mem_alu_out;
    assign mem_wb_mem_data = extend_load(mem_op, saved_rdata);

endmodule

/* data_memory.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module data_memory #(
    parameter int MEM_WORDS        = `MEM_WORDS,
    parameter int MEM_READ_LATENCY = `MEM_READ_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    cmd_start,
    input  logic                    cmd_write,
    output logic                    cmd_ready,
    input  logic [`CORE_XLEN-1:0]   addr,
    input  logic [`CORE_XLEN-1:0]   wdata,
    input  logic [`CORE_XLEN-1:0]   wmask,

    output logic                    rd_valid,
    output logic [`CORE_XLEN-1:0]   rdata
);

    import core_pkg::*;

    localparam int IDX_W  = $clog2(MEM_WORDS);
    localparam int LAT_W  = $clog2(MEM_READ_LATENCY + 1);
    localparam int BUSY_W = ($clog2(`MEM_WRITE_BUSY + 1) > 0) ?
                            $clog2(`MEM_WRITE_BUSY + 1) : 1;

    logic [`CORE_XLEN-1:0]  mem [MEM_WORDS];

    logic                   accept;
    logic [IDX_W-1:0]       word_idx;
    mem_word_u              old_word;
    mem_word_u              wr_word;
    mem_word_u              wr_mask;
    mem_word_u              new_word;

    logic [BUSY_W-1:0]      busy_cnt;
    logic [LAT_W-1:0]       lat_cnt;
    logic [`CORE_XLEN-1:0]  rd_data_q;

    // contents start at zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // **************************************************
    // word array
    // **************************************************

    assign accept   = cmd_start && cmd_ready;
    // word address, byte offset ignored
    assign word_idx = addr[IDX_W+1:2];

    assign old_word.word = mem[word_idx];
    assign wr_word.word  = wdata;
    assign wr_mask.word  = wmask;

    // merge byte by byte under the mask
    always_comb begin
        for (int b = 0; b < `CORE_XLEN/8; b++) begin
            new_word.bytes[b] = (wr_word.bytes[b] & wr_mask.bytes[b]) |
                                (old_word.bytes[b] & ~wr_mask.bytes[b]);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && cmd_write) begin
            mem[word_idx] <= new_word.word;
        end
    end

    // read data is taken at accept and held until the pulse
    always_ff @(posedge clk) begin
        if (accept && !cmd_write) begin
            rd_data_q <= old_word.word;
        end
    end

    // **************************************************
    // busy and latency counters
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
            lat_cnt  <= '0;
        end else begin
            if (accept && cmd_write) begin
                busy_cnt <= BUSY_W'(`MEM_WRITE_BUSY);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end

            // a new read restarts the count
            if (accept && !cmd_write) begin
                lat_cnt <= LAT_W'(MEM_READ_LATENCY);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    assign cmd_ready = (busy_cnt == '0);
    // last count of the read, one cycle wide
    assign rd_valid  = (lat_cnt == LAT_W'(1));
    assign rdata     = rd_data_q;

endmodule

/* mem_subsystem_top.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module mem_subsystem_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    mem_valid,
    input  logic [31:0]             mem_reg_pc,
    input  logic [31:0]             mem_inst,
    input  logic [63:0]             mem_inst_id,
    input  logic [3:0]              mem_op,
    input  logic [`CORE_XLEN-1:0]   mem_alu_out,
    input  logic [`CORE_XLEN-1:0]   mem_rs2_data,
    input  logic                    pipeline_flush,
    output logic                    memory_unit_stall,

    output logic                    mem_wb_valid,
    output logic [31:0]             mem_wb_reg_pc,
    output logic [31:0]             mem_wb_inst,
    output logic [63:0]             mem_wb_inst_id,
    output logic [3:0]              mem_wb_op,
    output logic [`CORE_XLEN-1:0]   mem_wb_alu_out,
    output logic [`CORE_XLEN-1:0]   mem_wb_mem_data
);

    // stage to memory wires
    logic                   memu_cmd_start;
    logic                   memu_cmd_write;
    logic                   memu_cmd_ready;
    logic                   memu_valid;
    logic [`CORE_XLEN-1:0]  memu_addr;
    logic [`CORE_XLEN-1:0]  memu_wdata;
    logic [`CORE_XLEN-1:0]  memu_wmask;
    logic [`CORE_XLEN-1:0]  memu_rdata;

    memory_stage u_memory_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_reg_pc        (mem_reg_pc),
        .mem_inst          (mem_inst),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_reg_pc     (mem_wb_reg_pc),
        .mem_wb_inst       (mem_wb_inst),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_op         (mem_wb_op),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_data   (mem_wb_mem_data),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall),
        .memu_cmd_start    (memu_cmd_start),
        .memu_cmd_write    (memu_cmd_write),
        .memu_cmd_ready    (memu_cmd_ready),
        .memu_valid        (memu_valid),
        .memu_addr         (memu_addr),
        .memu_wdata        (memu_wdata),
        .memu_wmask        (memu_wmask),
        .memu_rdata        (memu_rdata)
    );

    data_memory #(
        .MEM_WORDS        (`MEM_WORDS),
        .MEM_READ_LATENCY (`MEM_READ_LATENCY)
    ) u_data_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (memu_cmd_start),
        .cmd_write (memu_cmd_write),
        .cmd_ready (memu_cmd_ready),
        .addr      (memu_addr),
        .wdata     (memu_wdata),
        .wmask     (memu_wmask),
        .rd_valid  (memu_valid),
        .rdata     (memu_rdata)
    );

endmodule

/* mem_properties.sv */
`timescale 1ns/10ps

module mem_properties (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_valid,
    input  logic pipeline_flush,
    input  logic memory_unit_stall,
    input  logic memu_cmd_start,
    input  logic memu_cmd_write,
    input  logic memu_cmd_ready,
    input  logic memu_valid
);

    // read taken by the memory, its data not back yet
    logic read_pending;

    always_ff @(posedge clk) begin
        if (!rst_n || pipeline_flush || !mem_valid) begin
            read_pending <= 1'b0;
        end else if (memu_cmd_start && memu_cmd_ready && !memu_cmd_write) begin
            read_pending <= 1'b1;
        end else if (memu_valid) begin
            read_pending <= 1'b0;
        end
    end

    // no command while in reset
    assert property (@(posedge clk) !rst_n |-> !memu_cmd_start)
        else $error("command start high during reset");

    // start is held until the memory takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (memu_cmd_start && !memu_cmd_ready && !pipeline_flush) |=>
            (memu_cmd_start || pipeline_flush))
        else $error("command start dropped before ready");

    // an accepted read keeps the stall up until the memory returns its data
    assert property (@(posedge clk) disable iff (!rst_n)
        (read_pending && mem_valid && !pipeline_flush) |-> memory_unit_stall)
        else $error("stall low while a read is still pending");

endmodule

bind memory_stage mem_properties u_mem_properties (
    .clk               (clk),
    .rst_n             (rst_n),
    .mem_valid         (mem_valid),
    .pipeline_flush    (pipeline_flush),
    .memory_unit_stall (memory_unit_stall),
    .memu_cmd_start    (memu_cmd_start),
    .memu_cmd_write    (memu_cmd_write),
    .memu_cmd_ready    (memu_cmd_ready),
    .memu_valid        (memu_valid)
);

/* mem_checker.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module mem_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_valid,
    input  logic [31:0]             mem_reg_pc,
    input  logic [31:0]             mem_inst,
    input  logic [63:0]             mem_inst_id,
    input  logic [3:0]              mem_op,
    input  logic [`CORE_XLEN-1:0]   mem_alu_out,
    input  logic [`CORE_XLEN-1:0]   mem_rs2_data,
    input  logic                    pipeline_flush,
    input  logic                    memory_unit_stall,
    input  logic                    mem_wb_valid,
    input  logic [31:0]             mem_wb_reg_pc,
    input  logic [31:0]             mem_wb_inst,
    input  logic [63:0]             mem_wb_inst_id,
    input  logic [3:0]              mem_wb_op,
    input  logic [`CORE_XLEN-1:0]   mem_wb_alu_out,
    input  logic [`CORE_XLEN-1:0]   mem_wb_mem_data
);

    import core_pkg::*;

    logic [31:0]    model [`MEM_WORDS];
    int             test_count;
    int             error_count;
    logic           have_last;
    logic [63:0]    last_id;
    logic [31:0]    last_result;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model[i] = '0;
        end
        test_count  = 0;
        error_count = 0;
        have_last   = 1'b0;
        last_id     = '0;
        last_result = '0;
    end

    // sampled mid cycle, away from both edges
    always @(negedge clk) begin : compare
        int          idx;
        logic [31:0] old_word;
        logic [31:0] expect_data;
        logic        has_data;
        logic        fields_ok;

        if (rst_n && pipeline_flush) begin
            test_count++;
            have_last = 1'b0;
            if (mem_wb_valid) begin
                error_count++;
                $display("[ERROR] %0t: test %0d wb valid high during flush", $time, test_count);
            end else begin
                $display("test %0d flush: wb valid held low", test_count);
            end
        end else if (rst_n && mem_valid && !memory_unit_stall && mem_op != MEN_X) begin
            test_count++;
            idx         = int'((mem_alu_out >> 2) % `MEM_WORDS);
            old_word    = model[idx];
            expect_data = '0;
            has_data    = !(mem_op == MEN_SB || mem_op == MEN_SH || mem_op == MEN_SW);
            // wb side carries the completed instruction unchanged
            fields_ok   = (mem_wb_reg_pc === mem_reg_pc) && (mem_wb_inst === mem_inst) &&
                          (mem_wb_inst_id === mem_inst_id) && (mem_wb_op === mem_op) &&
                          (mem_wb_alu_out === mem_alu_out);
            if (have_last && last_id == mem_inst_id) begin
                // held instruction, nothing runs again
                expect_data = last_result;
            end else begin
                case (mem_op)
                    MEN_SB:  model[idx] = {old_word[31:8], mem_rs2_data[7:0]};
                    MEN_SH:  model[idx] = {old_word[31:16], mem_rs2_data[15:0]};
                    MEN_SW:  model[idx] = mem_rs2_data;
                    MEN_LB:  expect_data = {{24{old_word[7]}}, old_word[7:0]};
                    MEN_LBU: expect_data = {24'h0, old_word[7:0]};
                    MEN_LH:  expect_data = {{16{old_word[15]}}, old_word[15:0]};
                    MEN_LHU: expect_data = {16'h0, old_word[15:0]};
                    MEN_AMOSWAP_W_AQRL: begin
                        expect_data = old_word;
                        model[idx]  = mem_rs2_data;
                    end
                    default: expect_data = old_word;
                endcase
                have_last   = 1'b1;
                last_id     = mem_inst_id;
                last_result = expect_data;
            end
            if (!mem_wb_valid) begin
                error_count++;
                $display("[ERROR] %0t: test %0d wb valid low at completion", $time, test_count);
            end else if (!fields_ok) begin
                error_count++;
                $display("[ERROR] %0t: test %0d wb pc %h inst %h id %0d op %0d addr %h",
                         $time, test_count, mem_wb_reg_pc, mem_wb_inst, mem_wb_inst_id,
                         mem_wb_op, mem_wb_alu_out);
                $display("        expected pc %h inst %h id %0d op %0d addr %h",
                         mem_reg_pc, mem_inst, mem_inst_id, mem_op, mem_alu_out);
            end else if (has_data && mem_wb_mem_data !== expect_data) begin
                error_count++;
                $display("[ERROR] %0t: test %0d op %0d addr %h got %h expected %h", $time,
                         test_count, mem_op, mem_alu_out, mem_wb_mem_data, expect_data);
            end else begin
                $display("test %0d op %0d addr %h ok", test_count, mem_op, mem_alu_out);
            end
        end
    end

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module tb_mem_subsystem;

    import core_pkg::*;

    localparam int NUM_ROWS    = 26;
    localparam int WAIT_CYCLES = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   mem_valid;
    logic [31:0]            mem_reg_pc;
    logic [31:0]            mem_inst;
    logic [63:0]            mem_inst_id;
    logic [3:0]             mem_op;
    logic [`CORE_XLEN-1:0]  mem_alu_out;
    logic [`CORE_XLEN-1:0]  mem_rs2_data;
    logic                   pipeline_flush;
    logic                   memory_unit_stall;
    logic                   mem_wb_valid;
    logic [31:0]            mem_wb_reg_pc;
    logic [31:0]            mem_wb_inst;
    logic [63:0]            mem_wb_inst_id;
    logic [3:0]             mem_wb_op;
    logic [`CORE_XLEN-1:0]  mem_wb_alu_out;
    logic [`CORE_XLEN-1:0]  mem_wb_mem_data;

    // **************************************************
    // stimulus table
    // **************************************************

    logic [3:0]             row_op    [NUM_ROWS];
    logic [`CORE_XLEN-1:0]  row_addr  [NUM_ROWS];
    logic [`CORE_XLEN-1:0]  row_data  [NUM_ROWS];
    logic                   row_new   [NUM_ROWS];
    // cycles after issue before a flush pulse, 0 for none
    int                     row_flush [NUM_ROWS];
    int                     row_count;

    mem_subsystem_top UUT (.*);

    mem_checker u_checker (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_reg_pc        (mem_reg_pc),
        .mem_inst          (mem_inst),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_reg_pc     (mem_wb_reg_pc),
        .mem_wb_inst       (mem_wb_inst),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_op         (mem_wb_op),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_data   (mem_wb_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic new_id,
                           input int flush_after, input logic use_rand);
        row_op[row_count]    = op;
        row_addr[row_count]  = addr;
        row_data[row_count]  = use_rand ? $urandom() : data;
        row_new[row_count]   = new_id;
        row_flush[row_count] = flush_after;
        row_count++;
    endtask

    task automatic build_table();
        add_row(MEN_SW, 32'h10, 32'h12345678, 1'b1, 0, 1'b0);
        add_row(MEN_LW, 32'h10, 32'h0, 1'b1, 0, 1'b0);
        // partial stores merge into one word
        add_row(MEN_SW, 32'h20, 32'haabbccdd, 1'b1, 0, 1'b0);
        add_row(MEN_SB, 32'h20, 32'h998877ee, 1'b1, 0, 1'b0);
        add_row(MEN_SH, 32'h20, 32'h55661122, 1'b1, 0, 1'b0);
        add_row(MEN_LW, 32'h20, 32'h0, 1'b1, 0, 1'b0);
        // sign and zero extension
        add_row(MEN_SW, 32'h30, 32'h8081f2f3, 1'b1, 0, 1'b0);
        add_row(MEN_LB, 32'h30, 32'h0, 1'b1, 0, 1'b0);
        add_row(MEN_LBU, 32'h30, 32'h0, 1'b1, 0, 1'b0);
        add_row(MEN_LH, 32'h30, 32'h0, 1'b1, 0, 1'b0);
        add_row(MEN_LHU, 32'h30, 32'h0, 1'b1, 0, 1'b0);
        // swap
        add_row(MEN_SW, 32'h40, 32'h0, 1'b1, 0, 1'b1);
        add_row(MEN_AMOSWAP_W_AQRL, 32'h40, 32'h0, 1'b1, 0, 1'b1);
        add_row(MEN_LW, 32'h40, 32'h0, 1'b1, 0, 1'b0);
        // repeated stores with new ids, then a held swap
        add_row(MEN_SW, 32'h50, 32'h11110000, 1'b1, 0, 1'b0);
        add_row(MEN_AMOSWAP_W_AQRL, 32'h50, 32'h22220000, 1'b1, 0, 1'b0);
        add_row(MEN_SW, 32'h50, 32'h11110000, 1'b1, 0, 1'b0);
        add_row(MEN_AMOSWAP_W_AQRL, 32'h50, 32'h22220000, 1'b1, 0, 1'b0);
        add_row(MEN_AMOSWAP_W_AQRL, 32'h50, 32'h33330000, 1'b1, 0, 1'b0);
        add_row(MEN_AMOSWAP_W_AQRL, 32'h50, 32'h33330000, 1'b0, 0, 1'b0);
        add_row(MEN_LW, 32'h50, 32'h0, 1'b1, 0, 1'b0);
        // flushed load, then a normal one
        add_row(MEN_LW, 32'h20, 32'h0, 1'b1, 2, 1'b0);
        add_row(MEN_LW, 32'h20, 32'h0, 1'b1, 0, 1'b0);
        add_row(MEN_SW, 32'h70, 32'h0, 1'b1, 0, 1'b1);
        add_row(MEN_LB, 32'h70, 32'h0, 1'b1, 0, 1'b0);
        add_row(MEN_LHU, 32'h70, 32'h0, 1'b1, 0, 1'b0);
    endtask

    // **************************************************
    // driver loop
    // **************************************************

    initial begin
        int waited;
        logic timed_out;

        void'($urandom(79));
        row_count      = 0;
        timed_out      = 1'b0;
        rst_n          = 1'b0;
        mem_valid      = 1'b0;
        mem_reg_pc     = '0;
        mem_inst       = '0;
        mem_inst_id    = '0;
        mem_op         = MEN_X;
        mem_alu_out    = '0;
        mem_rs2_data   = '0;
        pipeline_flush = 1'b0;
        build_table();

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            @(posedge clk);
            #1;
            if (row_new[r]) begin
                mem_inst_id = mem_inst_id + 1;
            end
            mem_valid    = 1'b1;
            mem_reg_pc   = 32'h1000 + 32'(mem_inst_id) * 4;
            mem_inst     = {28'h0, row_op[r]};
            mem_op       = row_op[r];
            mem_alu_out  = row_addr[r];
            mem_rs2_data = row_data[r];
            if (row_flush[r] > 0) begin
                repeat (row_flush[r]) @(posedge clk);
                #1 pipeline_flush = 1'b1;
                @(posedge clk);
                #1;
                pipeline_flush = 1'b0;
                mem_valid      = 1'b0;
            end else begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (memory_unit_stall && waited < WAIT_CYCLES);
                if (memory_unit_stall) begin
                    $display("timeout: stall still high after %0d cycles on row %0d",
                             WAIT_CYCLES, r);
                    timed_out = 1'b1;
                end
            end
        end

        @(posedge clk);
        #1 mem_valid = 1'b0;
        repeat (3) @(posedge clk);

        $display("tests %0d, errors %0d", u_checker.test_count, u_checker.error_count);
        if (u_checker.test_count != NUM_ROWS) begin
            $display("only %0d of %0d tests finished", u_checker.test_count, NUM_ROWS);
        end
        if (!timed_out && u_checker.error_count == 0 && u_checker.test_count == NUM_ROWS) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
core_pkg.sv
memory_stage.sv
data_memory.sv
mem_subsystem_top.sv
mem_properties.sv
mem_checker.sv
tb_mem_subsystem.sv

/* run.sh */
#!/bin/bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
